// File: bench/rename_model.svh
// reference model of the rename core state
// map table, free list FIFO, ROB entries and the LCG
// included inside the testbench module

logic [31:0]                rng_state;
rename_pkg::phys_reg_t      model_map [rename_pkg::num_arch_regs];
rename_pkg::phys_reg_t      model_free [$];   // front is next tag handed out
rename_pkg::retire_slot_t   model_rob [$];    // front is the rob head
bit                         model_done [$];   // complete flag per rob entry
rename_pkg::rob_idx_t       model_head;
rename_pkg::rob_idx_t       model_tail;

// lcg step, low byte dropped
function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rng_state[31:8]};
endfunction

function automatic void reset_model();
    for (int r = 0; r < rename_pkg::num_arch_regs; r++) begin
        model_map[r] = rename_pkg::phys_reg_t'(r);   // identity
    end
    model_free.delete();
    for (int p = rename_pkg::num_arch_regs; p < rename_pkg::num_phys_regs; p++) begin
        model_free.push_back(rename_pkg::phys_reg_t'(p));
    end
    model_rob.delete();
    model_done.delete();
    model_head = '0;
    model_tail = '0;
endfunction

// rename in program order, so older lanes of the group are already in the map
function automatic rename_pkg::renamed_slot_t rename_one(input rename_pkg::fetch_slot_t ins);
    rename_pkg::renamed_slot_t r;
    r.valid     = 1'b1;
    r.dest_arch = ins.dest;
    r.src1_phys = model_map[ins.src1];
    r.src2_phys = model_map[ins.src2];
    r.old_phys  = model_map[ins.dest];
    r.dest_phys = model_free.pop_front();
    r.rob_idx   = model_tail;
    model_map[ins.dest] = r.dest_phys;
    model_tail = model_tail + 1'b1;
    model_rob.push_back('{valid: 1'b1, dest_arch: r.dest_arch,
                          dest_phys: r.dest_phys, old_phys: r.old_phys});
    model_done.push_back(1'b0);
    return r;
endfunction

// leading run of complete entries, at most one group
function automatic int retire_run();
    int n = 0;
    while (n < rename_pkg::num_lanes && n < model_rob.size() && model_done[n]) n++;
    return n;
endfunction

function automatic void retire_front(input int n);
    repeat (n) begin
        model_free.push_back(model_rob[0].old_phys);   // old tag recycled
        void'(model_rob.pop_front());
        void'(model_done.pop_front());
        model_head = model_head + 1'b1;
    end
endfunction

// offset from head of a random incomplete entry, -1 if none
function automatic int pick_incomplete();
    int cand [$];
    for (int k = 0; k < model_rob.size(); k++) begin
        if (!model_done[k]) cand.push_back(k);
    end
    if (cand.size() == 0) return -1;
    return cand[next_random() % cand.size()];
endfunction

// File: bench/rename_tb.sv
// testbench for the rename core
// random program, random fetch widths and completions,
// checked each cycle against the reference model
module rename_tb;

    localparam int num_instrs  = 600;
    localparam int idle_limit  = 2000;    // cycles without dispatch or retire
    localparam int cycle_limit = 40000;

    logic                           clock;
    logic                           reset;
    rename_pkg::fetch_bundle_t      fetch;
    rename_pkg::lane_count_t        fetch_take;
    rename_pkg::renamed_bundle_t    renamed;
    logic                           complete_valid;
    rename_pkg::rob_idx_t           complete_idx;
    rename_pkg::retire_bundle_t     retired;

    int                             mismatch_count;
    int                             other_count;
    int                             rob_stalls;   // cycles limited by rob space
    int                             presented;    // valid fetch slots this cycle
    int                             comp_offset;  // completion offset from head, -1 none
    rename_pkg::fetch_slot_t        instr_q [$];  // not yet taken
    rename_pkg::fetch_slot_t        pending [$];  // taken, waiting in the buffer

    `include "rename_model.svh"

    rename_core dut (
        .clock          (clock),
        .reset          (reset),
        .fetch          (fetch),
        .fetch_take     (fetch_take),
        .renamed        (renamed),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .retired        (retired)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_renamed(input int lane, input rename_pkg::renamed_slot_t got,
                                 input rename_pkg::renamed_slot_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            mismatch_count++;
            $display("MISMATCH t=%0t renamed[%0d]: got %h, expected %h", $time, lane, got, exp);
        end
    endtask

    task automatic check_retired(input int lane, input rename_pkg::retire_slot_t got,
                                 input rename_pkg::retire_slot_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            mismatch_count++;
            $display("MISMATCH t=%0t retired[%0d]: got %h, expected %h", $time, lane, got, exp);
        end
    endtask

    task automatic check_take(input rename_pkg::lane_count_t got,
                              input rename_pkg::lane_count_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t fetch_take: got %0d, expected %0d", $time, got, exp);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    // narrow range makes in-group dependencies common
    function automatic rename_pkg::arch_reg_t random_arch(input bit narrow);
        logic [31:0] r;
        r = next_random();
        return narrow ? rename_pkg::arch_reg_t'(r % 8) : rename_pkg::arch_reg_t'(r % 32);
    endfunction

    task automatic make_program();
        rename_pkg::fetch_slot_t ins;
        bit narrow;
        for (int k = 0; k < num_instrs; k++) begin
            narrow    = next_random() % 2;
            ins.valid = 1'b1;
            ins.dest  = random_arch(narrow);
            ins.src1  = random_arch(narrow);
            ins.src2  = random_arch(narrow);
            instr_q.push_back(ins);
        end
    endtask

    task automatic drive_inputs(input bit withhold);
        int n;
        case (next_random() % 8)   // mostly full groups
            0: n = 0;
            1: n = 1;
            2: n = 2;
            default: n = 3;
        endcase
        if (n > instr_q.size()) n = instr_q.size();
        presented = n;
        fetch = '0;
        for (int i = 0; i < n; i++) fetch[i] = instr_q[i];
        comp_offset = -1;
        if (!withhold && (next_random() % 100) < 60) comp_offset = pick_incomplete();
        complete_valid = (comp_offset >= 0);
        complete_idx   = complete_valid ? model_head + rename_pkg::rob_idx_t'(comp_offset) : '0;
    endtask

    //////////////////////////////
    // per cycle check and model step
    //////////////////////////////
    task automatic check_and_advance(output bit progress);
        int n_ret;
        int n_disp;
        int space;
        int n_take;
        rename_pkg::renamed_slot_t exp_ren;
        rename_pkg::retire_slot_t  exp_ret;
        n_ret = retire_run();
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            exp_ret = (i < n_ret) ? model_rob[i] : '0;
            check_retired(i, retired[i], exp_ret);
        end
        // dispatch limited by buffer contents, free tags and rob space
        space  = rename_pkg::rob_depth - model_rob.size();
        n_disp = pending.size();
        if (model_free.size() < n_disp) n_disp = model_free.size();
        if (space < pending.size()) rob_stalls++;
        if (space < n_disp) n_disp = space;
        check_take(fetch_take,
                   rename_pkg::lane_count_t'(rename_pkg::num_lanes - pending.size() + n_disp));
        if (comp_offset >= 0) model_done[comp_offset] = 1'b1;   // head not yet moved
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            if (i < n_disp) begin
                exp_ren = rename_one(pending.pop_front());
            end else begin
                exp_ren = '0;
            end
            check_renamed(i, renamed[i], exp_ren);
        end
        retire_front(n_ret);
        n_take = (fetch_take < presented) ? fetch_take : presented;
        repeat (n_take) pending.push_back(instr_q.pop_front());
        progress = (n_disp > 0) || (n_ret > 0);
    endtask

    initial begin : main
        bit progress;
        int idle;
        int cycle;
        rng_state      = 32'h7f0e_4ee7;
        reset          = 1'b1;
        fetch          = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        mismatch_count = 0;
        other_count    = 0;
        rob_stalls     = 0;
        presented      = 0;
        comp_offset    = -1;
        idle           = 0;
        cycle          = 0;
        make_program();
        reset_model();
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        while (other_count == 0 &&
               (instr_q.size() > 0 || pending.size() > 0 || model_rob.size() > 0)) begin
            drive_inputs((cycle % 300) >= 240);   // completion blackout, rob fills
            @(negedge clock);
            check_and_advance(progress);
            @(posedge clock);
            #2;
            cycle++;
            idle = progress ? 0 : idle + 1;
            if (idle >= idle_limit) begin
                other_count++;
                $display("timeout: no dispatch or retire for %0d cycles at t=%0t", idle, $time);
            end else if (cycle >= cycle_limit) begin
                other_count++;
                $display("timeout: program not drained after %0d cycles", cycle);
            end
        end
        if (rob_stalls == 0) begin
            other_count++;
            $display("error: the reorder buffer never limited dispatch");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
src/rename_pkg.sv
src/dispatch_buffer.sv
src/rename_lane.sv
src/map_table.sv
src/free_list.sv
src/reorder_buffer.sv
src/rename_core.sv
bench/rename_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the rename core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vrename_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: src/dispatch_buffer.sv
// dispatch buffer
// three-slot register between fetch and the rename lanes,
// held slots move to the front, freed slots refill from fetch
module dispatch_buffer (
    input  logic                                clock,
    input  logic                                reset,
    input  rename_pkg::fetch_bundle_t           fetch,
    input  logic [rename_pkg::num_lanes-1:0]    dispatched,  // per lane, empty counts as done
    output rename_pkg::fetch_bundle_t           slots,       // slot i feeds lane i
    output rename_pkg::lane_count_t             take         // fetch slots consumed this edge
);

    rename_pkg::fetch_bundle_t          slots_next;
    logic [rename_pkg::num_lanes-1:0]   fetch_valid;

    //////////////////////////////
    // next buffer contents
    //////////////////////////////
    always_comb begin
        int keep;   // valid slots held over
        keep = 0;
        slots_next = '0;
        // stalled instructions, oldest first
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            if (slots[i].valid && !dispatched[i]) begin
                slots_next[keep] = slots[i];
                keep++;
            end
        end
        // freed positions take fetch slots in order
        for (int j = 0; j < rename_pkg::num_lanes; j++) begin
            if (j >= keep) begin
                slots_next[j] = fetch[j - keep];
            end
        end
        // lanes stall as a suffix, so this is the dispatched leading run
        take = rename_pkg::lane_count_t'(rename_pkg::num_lanes - keep);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::num_lanes; i++) begin
                slots[i].valid <= 1'b0;   // payload left as is
            end
        end else begin
            slots <= slots_next;
        end
    end

    always_comb begin
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            fetch_valid[i] = fetch[i].valid;
        end
    end

    // fetch valids are a prefix, i.e. of the form 0..011..1
    fetch_prefix: assert property (@(posedge clock) disable iff (reset)
        ((fetch_valid & (fetch_valid + 1'b1)) == '0));

endmodule

// File: src/free_list.sv
// free list
// circular FIFO of free phys tags, 3-wide pop at dispatch,
// 3-wide push of retired old tags
module free_list (
    input  logic                                                clock,
    input  logic                                                reset,
    input  rename_pkg::renamed_bundle_t                         pop,
    input  rename_pkg::retire_bundle_t                          push,
    output rename_pkg::phys_reg_t [rename_pkg::num_lanes-1:0]   heads,
    output rename_pkg::free_count_t                             free_count
);

    typedef logic [$clog2(rename_pkg::num_phys_regs)-1:0] fl_ptr_t;

    rename_pkg::phys_reg_t      mem [rename_pkg::num_phys_regs];
    fl_ptr_t                    head;
    fl_ptr_t                    tail;
    rename_pkg::free_count_t    count;
    rename_pkg::lane_count_t    n_pop;
    rename_pkg::lane_count_t    n_push;

    // both bundles are prefixes, so counting valids is enough
    always_comb begin
        n_pop  = '0;
        n_push = '0;
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            if (pop[i].valid)  n_pop  = n_pop + 1'b1;
            if (push[i].valid) n_push = n_push + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            heads[i] = mem[head + fl_ptr_t'(i)];   // next three to hand out
        end
    end

    assign free_count = count;   // no same-cycle bypass of pushes

    //////////////////////////////
    // fifo state
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < rename_pkg::num_free_initial; k++) begin
                mem[k] <= rename_pkg::phys_reg_t'(rename_pkg::num_arch_regs + k);  // 32..63
            end
            head  <= '0;
            tail  <= fl_ptr_t'(rename_pkg::num_free_initial);
            count <= rename_pkg::free_count_t'(rename_pkg::num_free_initial);
        end else begin
            for (int i = 0; i < rename_pkg::num_lanes; i++) begin
                if (push[i].valid) mem[tail + fl_ptr_t'(i)] <= push[i].old_phys;
            end
            head  <= head + fl_ptr_t'(n_pop);
            tail  <= tail + fl_ptr_t'(n_push);
            count <= count + rename_pkg::free_count_t'(n_push)
                           - rename_pkg::free_count_t'(n_pop);
        end
    end

    // lanes never pop more than is free, and the list never overfills
    count_bound: assert property (@(posedge clock) disable iff (reset)
        (count <= rename_pkg::free_count_t'(rename_pkg::num_phys_regs)) &&
        (rename_pkg::free_count_t'(n_pop) <= count));

endmodule

// File: src/map_table.sv
// speculative map table
// arch to phys tags, three lookup groups, ordered group writes
module map_table (
    input  logic                                                clock,
    input  logic                                                reset,
    input  rename_pkg::arch_triple_t [rename_pkg::num_lanes-1:0] read_arch,
    output rename_pkg::phys_triple_t [rename_pkg::num_lanes-1:0] read_phys,
    input  rename_pkg::renamed_bundle_t                         writes
);

    rename_pkg::phys_reg_t tags [rename_pkg::num_arch_regs];

    //////////////////////////////
    // lookup, sees state before this edge's writes
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            read_phys[i].src1 = tags[read_arch[i].src1];
            read_phys[i].src2 = tags[read_arch[i].src2];
            read_phys[i].old  = tags[read_arch[i].dest];
        end
    end

    //////////////////////////////
    // update
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < rename_pkg::num_arch_regs; r++) begin
                tags[r] <= rename_pkg::phys_reg_t'(r);   // identity
            end
        end else begin
            // lane order, same dest in a group -> youngest lane stays
            for (int i = 0; i < rename_pkg::num_lanes; i++) begin
                if (writes[i].valid) begin
                    tags[writes[i].dest_arch] <= writes[i].dest_phys;
                end
            end
        end
    end

endmodule

// File: src/rename_core.sv
// rename core top
// dispatch buffer, three rename lanes, map table,
// free list and reorder buffer
module rename_core (
    input  logic                            clock,
    input  logic                            reset,
    input  rename_pkg::fetch_bundle_t       fetch,
    output rename_pkg::lane_count_t         fetch_take,
    output rename_pkg::renamed_bundle_t     renamed,
    input  logic                            complete_valid,
    input  rename_pkg::rob_idx_t            complete_idx,
    output rename_pkg::retire_bundle_t      retired
);

    rename_pkg::fetch_bundle_t                              slots;
    logic [rename_pkg::num_lanes:0]                         go_chain;   // [i] = lanes below i done
    rename_pkg::arch_triple_t [rename_pkg::num_lanes-1:0]   read_arch;
    rename_pkg::phys_triple_t [rename_pkg::num_lanes-1:0]   read_phys;
    rename_pkg::phys_reg_t [rename_pkg::num_lanes-1:0]      free_heads;
    rename_pkg::free_count_t                                free_count;
    rename_pkg::rob_count_t                                 rob_space;
    rename_pkg::rob_idx_t                                   rob_tail;

    assign go_chain[0] = 1'b1;   // lane 0 has no older lane

    dispatch_buffer u_buffer (
        .clock      (clock),
        .reset      (reset),
        .fetch      (fetch),
        .dispatched (go_chain[rename_pkg::num_lanes:1]),
        .slots      (slots),
        .take       (fetch_take)
    );

    //////////////////////////////
    // rename lanes
    //////////////////////////////
    for (genvar i = 0; i < rename_pkg::num_lanes; i++) begin : g_lane
        assign read_arch[i] = '{src1: slots[i].src1, src2: slots[i].src2, dest: slots[i].dest};

        rename_lane #(.lane_index(i)) u_lane (
            .slot       (slots[i]),
            .older      (renamed),
            .older_go   (go_chain[i]),
            .free_count (free_count),
            .rob_space  (rob_space),
            .new_phys   (free_heads[i]),
            .rob_idx    (rob_tail),      // lane adds its own offset
            .map_src1   (read_phys[i].src1),
            .map_src2   (read_phys[i].src2),
            .map_old    (read_phys[i].old),
            .renamed    (renamed[i]),
            .go         (go_chain[i+1])
        );
    end

    //////////////////////////////
    // shared state
    //////////////////////////////
    map_table u_map (
        .clock      (clock),
        .reset      (reset),
        .read_arch  (read_arch),
        .read_phys  (read_phys),
        .writes     (renamed)
    );

    free_list u_free (
        .clock      (clock),
        .reset      (reset),
        .pop        (renamed),
        .push       (retired),   // old tags come back at retire
        .heads      (free_heads),
        .free_count (free_count)
    );

    reorder_buffer u_rob (
        .clock          (clock),
        .reset          (reset),
        .alloc          (renamed),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .tail           (rob_tail),
        .rob_space      (rob_space),
        .retired        (retired)
    );

endmodule

// File: src/rename_lane.sv
// rename lane
// dispatch decision against free list and rob space,
// in-group forwarding of older lanes' new tags
module rename_lane #(
    parameter int lane_index = 0
) (
    input  rename_pkg::fetch_slot_t     slot,
    input  rename_pkg::renamed_bundle_t older,       // whole group, only j < lane_index read
    input  logic                        older_go,    // all older lanes dispatched
    input  rename_pkg::free_count_t     free_count,
    input  rename_pkg::rob_count_t      rob_space,
    input  rename_pkg::phys_reg_t       new_phys,    // free list slot lane_index
    input  rename_pkg::rob_idx_t        rob_idx,     // group base, the rob tail
    input  rename_pkg::phys_reg_t       map_src1,
    input  rename_pkg::phys_reg_t       map_src2,
    input  rename_pkg::phys_reg_t       map_old,
    output rename_pkg::renamed_slot_t   renamed,
    output logic                        go
);

    logic                   fits;   // enough regs and rob entries up to this lane
    rename_pkg::phys_reg_t  src1_phys;
    rename_pkg::phys_reg_t  src2_phys;
    rename_pkg::phys_reg_t  old_phys;

    assign fits = (rename_pkg::free_count_t'(lane_index + 1) <= free_count) &&
                  (rename_pkg::rob_count_t'(lane_index + 1) <= rob_space);
    assign go   = !slot.valid || (older_go && fits);   // empty slot never blocks

    // forwarding, later j overrides so the youngest older writer wins
    always_comb begin
        src1_phys = map_src1;
        src2_phys = map_src2;
        old_phys  = map_old;
        for (int j = 0; j < lane_index; j++) begin
            if (older[j].valid && older[j].dest_arch == slot.src1) src1_phys = older[j].dest_phys;
            if (older[j].valid && older[j].dest_arch == slot.src2) src2_phys = older[j].dest_phys;
            if (older[j].valid && older[j].dest_arch == slot.dest) old_phys  = older[j].dest_phys;
        end
    end

    assign renamed = '{
        valid:     slot.valid && older_go && fits,
        dest_arch: slot.dest,
        dest_phys: new_phys,
        old_phys:  old_phys,
        src1_phys: src1_phys,
        src2_phys: src2_phys,
        rob_idx:   rob_idx + rename_pkg::rob_idx_t'(lane_index)   // wraps with the rob
    };

endmodule

// File: src/rename_pkg.sv
// rename core shared definitions
// sizes, vector typedefs, fetch / rename / retire bundle structs
package rename_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int num_lanes        = 3;    // rename width
    localparam int num_arch_regs    = 32;
    localparam int num_phys_regs    = 64;
    localparam int rob_depth        = 16;
    localparam int num_free_initial = num_phys_regs - num_arch_regs;  // 32 free at reset

    //////////////////////////////
    // vector types
    //////////////////////////////
    typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;    // 5 bits
    typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;    // 6 bits
    typedef logic [$clog2(rob_depth)-1:0]     rob_idx_t;     // 4 bits
    typedef logic [1:0]                       lane_count_t;  // 0..3 per group
    typedef logic [$clog2(num_phys_regs):0]   free_count_t;  // 0..64
    typedef logic [$clog2(rob_depth):0]       rob_count_t;   // 0..16

    //////////////////////////////
    // bundles
    //////////////////////////////
    // one fetched instruction, 16 bits
    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } fetch_slot_t;

    typedef fetch_slot_t [num_lanes-1:0] fetch_bundle_t;  // slot 0 oldest

    // rename result, 34 bits; valid means it went into the rob
    typedef struct packed {
        logic      valid;
        arch_reg_t dest_arch;
        phys_reg_t dest_phys;
        phys_reg_t old_phys;   // previous mapping, freed at retire
        phys_reg_t src1_phys;
        phys_reg_t src2_phys;
        rob_idx_t  rob_idx;
    } renamed_slot_t;

    typedef renamed_slot_t [num_lanes-1:0] renamed_bundle_t;

    // retiring entry, 18 bits
    typedef struct packed {
        logic      valid;
        arch_reg_t dest_arch;
        phys_reg_t dest_phys;
        phys_reg_t old_phys;
    } retire_slot_t;

    typedef retire_slot_t [num_lanes-1:0] retire_bundle_t;

    // map table lookup per lane
    typedef struct packed {
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
    } arch_triple_t;

    typedef struct packed {
        phys_reg_t src1;
        phys_reg_t src2;
        phys_reg_t old;    // current mapping of dest
    } phys_triple_t;

endpackage

// File: src/reorder_buffer.sv
// reorder buffer
// circular entry store with group allocate, completion marking
// and in-order retire of up to three entries per cycle
module reorder_buffer (
    input  logic                            clock,
    input  logic                            reset,
    input  rename_pkg::renamed_bundle_t     alloc,
    input  logic                            complete_valid,
    input  rename_pkg::rob_idx_t            complete_idx,
    output rename_pkg::rob_idx_t            tail,        // base index of the next group
    output rename_pkg::rob_count_t          rob_space,
    output rename_pkg::retire_bundle_t      retired
);

    // entry payload
    rename_pkg::arch_reg_t  dest_arch [rename_pkg::rob_depth];
    rename_pkg::phys_reg_t  dest_phys [rename_pkg::rob_depth];
    rename_pkg::phys_reg_t  old_phys  [rename_pkg::rob_depth];

    logic [rename_pkg::rob_depth-1:0]   done;         // per entry complete
    rename_pkg::rob_idx_t               head;
    rename_pkg::rob_count_t             count;        // occupied entries
    rename_pkg::lane_count_t            n_alloc;
    rename_pkg::lane_count_t            n_retire;
    rename_pkg::rob_idx_t               comp_offset;  // completion distance from head

    assign rob_space = rename_pkg::rob_count_t'(rename_pkg::rob_depth) - count;

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            if (alloc[i].valid) n_alloc = n_alloc + 1'b1;
        end
    end

    //////////////////////////////
    // retire select
    //////////////////////////////
    always_comb begin : retire_select
        rename_pkg::rob_idx_t idx;
        logic run;   // still inside the leading run of done entries
        run      = 1'b1;
        n_retire = '0;
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            idx = head + rename_pkg::rob_idx_t'(i);
            run = run && (rename_pkg::rob_count_t'(i) < count) && done[idx];
            retired[i].valid     = run;
            retired[i].dest_arch = dest_arch[idx];
            retired[i].dest_phys = dest_phys[idx];
            retired[i].old_phys  = old_phys[idx];
            if (run) n_retire = n_retire + 1'b1;
        end
    end

    //////////////////////////////
    // pointers and done bits
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            for (int i = 0; i < rename_pkg::num_lanes; i++) begin
                if (alloc[i].valid) done[alloc[i].rob_idx] <= 1'b0;   // fresh entry
            end
            if (complete_valid) done[complete_idx] <= 1'b1;
            head  <= head + rename_pkg::rob_idx_t'(n_retire);
            tail  <= tail + rename_pkg::rob_idx_t'(n_alloc);
            count <= count + rename_pkg::rob_count_t'(n_alloc)
                           - rename_pkg::rob_count_t'(n_retire);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rename_pkg::num_lanes; i++) begin
            if (alloc[i].valid) begin
                dest_arch[alloc[i].rob_idx] <= alloc[i].dest_arch;
                dest_phys[alloc[i].rob_idx] <= alloc[i].dest_phys;
                old_phys[alloc[i].rob_idx]  <= alloc[i].old_phys;
            end
        end
    end

    assign comp_offset = complete_idx - head;

    // completion must hit an occupied entry that is not yet done
    complete_legal: assert property (@(posedge clock) disable iff (reset)
        complete_valid |->
            (rename_pkg::rob_count_t'(comp_offset) < count) && !done[complete_idx]);

endmodule
